//--- assoc_lookup.f
assoc_lookup_pkg.sv
lookup_request_queue.sv
tag_store.sv
pseudo_lru.sv
lookup_sequencer.sv
response_output.sv
assoc_lookup_top.sv
assoc_lookup_monitor.sv
assoc_lookup_checker.sv
tb_assoc_lookup.sv

//--- Bender.yml
package:
  name: assoc_lookup

sources:
  - assoc_lookup_pkg.sv
  - lookup_request_queue.sv
  - tag_store.sv
  - pseudo_lru.sv
  - lookup_sequencer.sv
  - response_output.sv
  - assoc_lookup_top.sv
  - target: test
    files:
      - assoc_lookup_monitor.sv
      - assoc_lookup_checker.sv
      - tb_assoc_lookup.sv

//--- tb_assoc_lookup.sv
`timescale 1ns/100ps
`default_nettype none

module tb_assoc_lookup;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int COLD_REQS = assoc_lookup_pkg::WAYS;
	localparam int HIT_REQS = 2;
	localparam int RANDOM_REQS = 300;
	localparam int STALL_REQS = assoc_lookup_pkg::REQ_DEPTH + 2;
	localparam int TOTAL_REQS = COLD_REQS + HIT_REQS + RANDOM_REQS + STALL_REQS;
	localparam int POOL_SIZE = 12;

	logic clk;
	logic rst;
	logic req_valid;
	assoc_lookup_pkg::tag_t req_tag;
	logic req_credit;
	logic rsp_valid;
	logic rsp_hit;
	assoc_lookup_pkg::way_t rsp_way;
	assoc_lookup_pkg::tag_t rsp_tag;
	logic rsp_credit;
	logic hold_credits;
	int req_credits;
	int cycle;
	int ret_q [$];
	int tests_run;
	int tests_failed;
	int errs_before;

	assoc_lookup_top UUT (.*);

	assoc_lookup_monitor u_mon (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Sender credits, and delayed credit return toward the DUT.
	always @(posedge clk) begin
		cycle++;
		if (req_credit) req_credits++;
		if (rsp_valid) ret_q.push_back(cycle + $urandom_range(1, 4));
		#1;
		rsp_credit = 1'b0;
		if (!hold_credits && ret_q.size() != 0 && ret_q[0] <= cycle) begin
			rsp_credit = 1'b1;
			void'(ret_q.pop_front());
		end
	end

	function automatic int total_errors();
		return u_mon.errors + UUT.u_queue.u_queue_chk.failures + UUT.u_out.u_out_chk.failures;
	endfunction

	function automatic assoc_lookup_pkg::tag_t pool_tag();
		return assoc_lookup_pkg::tag_t'(12'h100 + $urandom_range(0, POOL_SIZE - 1));
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_req(input assoc_lookup_pkg::tag_t tag);
		while (req_credits == 0) idle_cycles(1);
		req_valid = 1'b1;
		req_tag = tag;
		req_credits--;
		idle_cycles(1);
		req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (u_mon.pending != 0 || ret_q.size() != 0) idle_cycles(1);
	endtask

	task automatic finish_test(input int num, input string name);
		int errs;
		wait_drain();
		errs = total_errors() - errs_before;
		errs_before = total_errors();
		tests_run++;
		if (errs != 0) tests_failed++;
		$display("test %0d %s: %0d responses so far, %0d errors", num, name, u_mon.responses, errs);
	endtask

	initial begin
		void'($urandom(32'h229d));
		rst = 1'b1;
		req_valid = 1'b0;
		req_tag = '0;
		rsp_credit = 1'b0;
		hold_credits = 1'b0;
		req_credits = assoc_lookup_pkg::REQ_DEPTH;
		cycle = 0;
		tests_run = 0;
		tests_failed = 0;
		errs_before = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;

		for (int i = 0; i < COLD_REQS; i++) send_req(assoc_lookup_pkg::tag_t'(12'h800 + i));
		finish_test(1, "cold fill");

		send_req(12'h803);                   // Stored in way 6.
		send_req(12'h900);
		finish_test(2, "hit then miss");

		for (int i = 0; i < RANDOM_REQS; i++) begin
			send_req(pool_tag());
			idle_cycles($urandom_range(0, 2));
		end
		finish_test(3, "random mix");

		hold_credits = 1'b1;
		for (int i = 0; i < STALL_REQS; i++) send_req(pool_tag());
		idle_cycles(50);
		hold_credits = 1'b0;
		finish_test(4, "response back-pressure");

		u_mon.final_check();
		finish_test(5, "request credits");

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			total_errors());
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(TOTAL_REQS * 40 * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", TOTAL_REQS * 40);
		$display("TB FAILED");
		$finish;
	end

endmodule : tb_assoc_lookup

`default_nettype wire

//--- assoc_lookup_checker.sv
`timescale 1ns/100ps
`default_nettype none

module assoc_lookup_checker (
	input logic       clk,
	input logic       rst,
	input logic       push,
	input logic       blocked,
	input logic       strobe,
	input logic       settle,
	input logic [7:0] level,
	input logic [7:0] limit
);

	int failures = 0;

	property push_not_blocked;
		@(posedge clk) disable iff (rst) push |-> !blocked;
	endproperty

	property level_in_range;
		@(posedge clk) disable iff (rst) level <= limit;
	endproperty

	// A credit pulse or a handover is followed by a low cycle.
	property strobe_then_low;
		@(posedge clk) disable iff (rst) strobe |=> !settle;
	endproperty

	assert property (push_not_blocked) else begin
		failures++;
		$error("Write into a full queue or credit returned with none outstanding");
	end

	assert property (level_in_range) else begin
		failures++;
		$error("Occupancy or credit count above its limit");
	end

	assert property (strobe_then_low) else begin
		failures++;
		$error("Credit pulse or valid still high the cycle after it must drop");
	end

endmodule : assoc_lookup_checker

bind lookup_request_queue assoc_lookup_checker u_queue_chk (
	.clk     (clk),
	.rst     (rst),
	.push    (req_valid),
	.blocked (full),
	.strobe  (req_credit),
	.settle  (req_credit),
	.level   (8'(count) + 8'(req_credit) + 8'(req_valid)),   // Sender credits in use.
	.limit   (8'(assoc_lookup_pkg::REQ_DEPTH))
);

bind response_output assoc_lookup_checker u_out_chk (
	.clk     (clk),
	.rst     (rst),
	.push    (rsp_credit),
	.blocked (credits == assoc_lookup_pkg::rsp_cnt_t'(assoc_lookup_pkg::RSP_CREDITS)),
	.strobe  (xfer),
	.settle  (out_valid),
	.level   (8'(credits)),
	.limit   (8'(assoc_lookup_pkg::RSP_CREDITS))
);

`default_nettype wire

//--- assoc_lookup_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module assoc_lookup_monitor (
	input logic                   clk,
	input logic                   rst,
	input logic                   req_valid,
	input assoc_lookup_pkg::tag_t req_tag,
	input logic                   req_credit,
	input logic                   rsp_valid,
	input logic                   rsp_hit,
	input assoc_lookup_pkg::way_t rsp_way,
	input assoc_lookup_pkg::tag_t rsp_tag,
	input logic                   rsp_credit
);

	int cold_ways [assoc_lookup_pkg::WAYS] = '{0, 4, 2, 6, 1, 5, 3, 7};
	assoc_lookup_pkg::tag_t model_tags [assoc_lookup_pkg::WAYS];
	assoc_lookup_pkg::way_mask_t model_valid;
	assoc_lookup_pkg::lru_bits_t model_lru;
	assoc_lookup_pkg::tag_t exp_q [$];
	int errors = 0;
	int responses = 0;
	int accepted = 0;
	int credit_pulses = 0;
	int credits_back = 0;
	int pending = 0;

	// Follow the tree from the root, a 0 bit goes left.
	function automatic assoc_lookup_pkg::way_t walk_victim(assoc_lookup_pkg::lru_bits_t bits);
		int node;
		node = 0;
		repeat (assoc_lookup_pkg::WAY_W) node = 2 * node + 1 + int'(bits[node]);
		return assoc_lookup_pkg::way_t'(node - assoc_lookup_pkg::LRU_W);
	endfunction

	function automatic assoc_lookup_pkg::lru_bits_t mark_used(assoc_lookup_pkg::lru_bits_t bits,
			assoc_lookup_pkg::way_t way);
		int node;
		logic dir;
		node = 0;
		for (int lvl = assoc_lookup_pkg::WAY_W - 1; lvl >= 0; lvl--) begin
			dir = way[lvl];
			bits[node] = ~dir;                   // Point away from the way.
			node = 2 * node + 1 + int'(dir);
		end
		return bits;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Mismatch at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
		end
	endtask

	task automatic score_response();
		assoc_lookup_pkg::tag_t tag;
		logic exp_hit;
		assoc_lookup_pkg::way_t exp_way;
		if (exp_q.size() == 0) begin
			errors++;
			$display("Response at %0t arrived with no request outstanding", $time);
			return;
		end
		tag = exp_q.pop_front();
		exp_hit = 1'b0;
		exp_way = '0;
		for (int i = assoc_lookup_pkg::WAYS - 1; i >= 0; i--) begin
			if (model_valid[i] && model_tags[i] == tag) begin
				exp_hit = 1'b1;
				exp_way = assoc_lookup_pkg::way_t'(i);
			end
		end
		if (!exp_hit) begin
			exp_way = walk_victim(model_lru);
			model_tags[exp_way] = tag;
			model_valid[exp_way] = 1'b1;
		end
		model_lru = mark_used(model_lru, exp_way);
		if (responses < assoc_lookup_pkg::WAYS) begin
			compare("rsp_way (cold fill order)", cold_ways[responses], rsp_way);
		end
		compare("rsp_hit", exp_hit, rsp_hit);
		compare("rsp_way", exp_way, rsp_way);
		compare("rsp_tag", tag, rsp_tag);
		if (responses + 1 > assoc_lookup_pkg::RSP_CREDITS + credits_back) begin
			errors++;
			$display("Response at %0t was sent without a response credit", $time);
		end
		responses++;
	endtask

	task automatic final_check();
		if (accepted != credit_pulses) begin
			errors++;
			$display("Request credits returned (%0d) differ from requests accepted (%0d)",
				credit_pulses, accepted);
		end
		if (pending != 0) begin
			errors++;
			$display("%0d responses never arrived", pending);
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			model_valid = '0;
			model_lru = '0;
			exp_q.delete();
			pending = 0;
		end else begin
			if (req_valid) begin
				exp_q.push_back(req_tag);
				accepted++;
			end
			if (req_credit) credit_pulses++;
			if (rsp_credit) credits_back++;
			if (rsp_valid) score_response();
			pending = exp_q.size();
		end
	end

endmodule : assoc_lookup_monitor

`default_nettype wire

//--- assoc_lookup_top.sv
`timescale 1ns/100ps
`default_nettype none

module assoc_lookup_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	input  assoc_lookup_pkg::tag_t req_tag,
	output logic                   req_credit,
	output logic                   rsp_valid,
	output logic                   rsp_hit,
	output assoc_lookup_pkg::way_t rsp_way,
	output assoc_lookup_pkg::tag_t rsp_tag,
	input  logic                   rsp_credit
);

	logic q_valid;
	logic q_pop;
	assoc_lookup_pkg::tag_t q_tag;
	assoc_lookup_pkg::tag_t lookup_tag;
	logic hit;
	assoc_lookup_pkg::way_t hit_way;
	logic fill;
	assoc_lookup_pkg::way_t fill_way;
	logic touch;
	assoc_lookup_pkg::way_t touch_way;
	logic find;
	logic victim_valid;
	assoc_lookup_pkg::way_t victim_way;
	logic out_valid;
	logic out_ready;
	logic out_hit;
	assoc_lookup_pkg::way_t out_way;
	assoc_lookup_pkg::tag_t out_tag;

	lookup_request_queue u_queue (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_tag    (req_tag),
		.q_pop      (q_pop),
		.q_valid    (q_valid),
		.q_tag      (q_tag),
		.req_credit (req_credit)
	);

	lookup_sequencer u_seq (
		.clk          (clk),
		.rst          (rst),
		.q_valid      (q_valid),
		.q_tag        (q_tag),
		.q_pop        (q_pop),
		.lookup_tag   (lookup_tag),
		.hit          (hit),
		.hit_way      (hit_way),
		.fill         (fill),
		.fill_way     (fill_way),
		.touch        (touch),
		.touch_way    (touch_way),
		.find         (find),
		.victim_valid (victim_valid),
		.victim_way   (victim_way),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_hit      (out_hit),
		.out_way      (out_way),
		.out_tag      (out_tag)
	);

	tag_store u_tags (
		.clk        (clk),
		.rst        (rst),
		.lookup_tag (lookup_tag),
		.hit        (hit),
		.hit_way    (hit_way),
		.fill       (fill),
		.fill_way   (fill_way),
		.fill_tag   (lookup_tag)   // Miss fills the tag being looked up.
	);

	pseudo_lru u_plru (
		.clk          (clk),
		.rst          (rst),
		.touch        (touch),
		.touch_way    (touch_way),
		.find         (find),
		.victim_valid (victim_valid),
		.victim_way   (victim_way)
	);

	response_output u_out (
		.clk        (clk),
		.rst        (rst),
		.out_valid  (out_valid),
		.out_hit    (out_hit),
		.out_way    (out_way),
		.out_tag    (out_tag),
		.out_ready  (out_ready),
		.rsp_valid  (rsp_valid),
		.rsp_hit    (rsp_hit),
		.rsp_way    (rsp_way),
		.rsp_tag    (rsp_tag),
		.rsp_credit (rsp_credit)
	);

endmodule : assoc_lookup_top

`default_nettype wire

//--- response_output.sv
`timescale 1ns/100ps
`default_nettype none

module response_output (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   out_valid,
	input  logic                   out_hit,
	input  assoc_lookup_pkg::way_t out_way,
	input  assoc_lookup_pkg::tag_t out_tag,
	output logic                   out_ready,
	output logic                   rsp_valid,
	output logic                   rsp_hit,
	output assoc_lookup_pkg::way_t rsp_way,
	output assoc_lookup_pkg::tag_t rsp_tag,
	input  logic                   rsp_credit
);

	assoc_lookup_pkg::rsp_cnt_t credits;
	logic xfer;

	// Register is busy while rsp_valid is up.
	assign out_ready = (credits != '0) && !rsp_valid;
	assign xfer = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= assoc_lookup_pkg::rsp_cnt_t'(assoc_lookup_pkg::RSP_CREDITS);
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= xfer;
			case ({xfer, rsp_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;   // Both or neither.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (xfer) begin
			rsp_hit <= out_hit;
			rsp_way <= out_way;
			rsp_tag <= out_tag;
		end
	end

endmodule : response_output

`default_nettype wire

//--- lookup_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module lookup_sequencer (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   q_valid,
	input  assoc_lookup_pkg::tag_t q_tag,
	output logic                   q_pop,
	output assoc_lookup_pkg::tag_t lookup_tag,
	input  logic                   hit,
	input  assoc_lookup_pkg::way_t hit_way,
	output logic                   fill,
	output assoc_lookup_pkg::way_t fill_way,
	output logic                   touch,
	output assoc_lookup_pkg::way_t touch_way,
	output logic                   find,
	input  logic                   victim_valid,
	input  assoc_lookup_pkg::way_t victim_way,
	output logic                   out_valid,
	input  logic                   out_ready,
	output logic                   out_hit,
	output assoc_lookup_pkg::way_t out_way,
	output assoc_lookup_pkg::tag_t out_tag
);

	assoc_lookup_pkg::seq_state_t state;
	assoc_lookup_pkg::tag_t cur_tag;
	logic lookup_hit;

	assign lookup_hit = (state == assoc_lookup_pkg::lookup) && hit;

	assign q_pop = (state == assoc_lookup_pkg::idle) && q_valid;
	assign lookup_tag = cur_tag;
	assign out_tag = cur_tag;
	assign out_valid = (state == assoc_lookup_pkg::respond);
	assign find = (state == assoc_lookup_pkg::lookup) && !hit;      // Start the walk.
	assign fill = (state == assoc_lookup_pkg::victim_wait) && victim_valid;
	assign fill_way = victim_way;
	assign touch = lookup_hit || fill;
	assign touch_way = lookup_hit ? hit_way : victim_way;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= assoc_lookup_pkg::idle;
		end else begin
			case (state)
				assoc_lookup_pkg::idle:
					if (q_valid) state <= assoc_lookup_pkg::lookup;
				assoc_lookup_pkg::lookup:
					state <= hit ? assoc_lookup_pkg::respond : assoc_lookup_pkg::victim_wait;
				assoc_lookup_pkg::victim_wait:
					if (victim_valid) state <= assoc_lookup_pkg::respond;
				assoc_lookup_pkg::respond:
					if (out_ready) state <= assoc_lookup_pkg::idle;   // Handed over.
				default: state <= assoc_lookup_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (q_pop) begin
			cur_tag <= q_tag;
		end
		if (lookup_hit) begin
			out_hit <= 1'b1;
			out_way <= hit_way;
		end else if (fill) begin
			out_hit <= 1'b0;
			out_way <= victim_way;                // Way just filled.
		end
	end

endmodule : lookup_sequencer

`default_nettype wire

//--- pseudo_lru.sv
`timescale 1ns/100ps
`default_nettype none

module pseudo_lru (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   touch,
	input  assoc_lookup_pkg::way_t touch_way,
	input  logic                   find,
	output logic                   victim_valid,
	output assoc_lookup_pkg::way_t victim_way
);

	assoc_lookup_pkg::lru_bits_t lru_bits;
	assoc_lookup_pkg::lru_bits_t lru_next;
	assoc_lookup_pkg::plru_state_t state;
	assoc_lookup_pkg::node_t node;
	assoc_lookup_pkg::node_t node_next;
	assoc_lookup_pkg::node_t leaf_ofs;
	logic at_leaf;

	// Every node on the touched path points away from that way.
	always_comb begin
		lru_next = lru_bits;
		if (touch) begin
			for (int lvl = 0; lvl < assoc_lookup_pkg::WAY_W; lvl++) begin
				lru_next[(2 ** lvl - 1) + (touch_way >> (assoc_lookup_pkg::WAY_W - lvl))] =
					~touch_way[assoc_lookup_pkg::WAY_W - 1 - lvl];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lru_bits <= '0;
		end else begin
			lru_bits <= lru_next;
		end
	end

	assign at_leaf = (node >= assoc_lookup_pkg::LEAF_BASE);
	assign leaf_ofs = node - assoc_lookup_pkg::LEAF_BASE;   // Way pair index.

	// Child 2i+1 on a 0 bit, 2i+2 on a 1 bit.
	assign node_next = (node << 1) + assoc_lookup_pkg::node_t'(1) +
		assoc_lookup_pkg::node_t'(lru_bits[node]);

	// One tree level per cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= assoc_lookup_pkg::walk_idle;
			node <= '0;
			victim_valid <= 1'b0;
		end else begin
			victim_valid <= 1'b0;
			case (state)
				assoc_lookup_pkg::walk_idle: begin
					if (find) begin
						node <= assoc_lookup_pkg::node_t'(1) +
							assoc_lookup_pkg::node_t'(lru_bits[0]); // Root step.
						state <= assoc_lookup_pkg::walking;
					end
				end
				assoc_lookup_pkg::walking: begin
					if (at_leaf) begin
						victim_valid <= 1'b1;
						state <= assoc_lookup_pkg::walk_idle;
					end else begin
						node <= node_next;
					end
				end
				default: state <= assoc_lookup_pkg::walk_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == assoc_lookup_pkg::walking && at_leaf) begin
			victim_way <= {leaf_ofs[assoc_lookup_pkg::WAY_W-2:0], lru_bits[node]};
		end
	end

endmodule : pseudo_lru

`default_nettype wire

//--- tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module tag_store (
	input  logic                   clk,
	input  logic                   rst,
	input  assoc_lookup_pkg::tag_t lookup_tag,
	output logic                   hit,
	output assoc_lookup_pkg::way_t hit_way,
	input  logic                   fill,
	input  assoc_lookup_pkg::way_t fill_way,
	input  assoc_lookup_pkg::tag_t fill_tag
);

	assoc_lookup_pkg::tag_t tags [assoc_lookup_pkg::WAYS];
	assoc_lookup_pkg::way_mask_t valid;
	assoc_lookup_pkg::way_mask_t match;

	always_ff @(posedge clk) begin
		if (fill) begin
			tags[fill_way] <= fill_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;                 // All ways empty.
		end else if (fill) begin
			valid[fill_way] <= 1'b1;
		end
	end

	// Compare every way at once.
	always_comb begin
		for (int i = 0; i < assoc_lookup_pkg::WAYS; i++) begin
			match[i] = valid[i] && (tags[i] == lookup_tag);
		end
	end

	assign hit = |match;

	always_comb begin
		hit_way = '0;
		for (int i = assoc_lookup_pkg::WAYS - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit_way = assoc_lookup_pkg::way_t'(i); // Lowest way wins.
			end
		end
	end

endmodule : tag_store

`default_nettype wire

//--- lookup_request_queue.sv
`timescale 1ns/100ps
`default_nettype none

module lookup_request_queue (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   req_valid,
	input  assoc_lookup_pkg::tag_t req_tag,
	input  logic                   q_pop,
	output logic                   q_valid,
	output assoc_lookup_pkg::tag_t q_tag,
	output logic                   req_credit
);

	assoc_lookup_pkg::tag_t mem [assoc_lookup_pkg::REQ_DEPTH];
	assoc_lookup_pkg::req_ptr_t wr_ptr;
	assoc_lookup_pkg::req_ptr_t rd_ptr;
	assoc_lookup_pkg::req_cnt_t count;
	logic full;
	logic push;
	logic pop;

	assign full = (count == assoc_lookup_pkg::req_cnt_t'(assoc_lookup_pkg::REQ_DEPTH));
	assign push = req_valid && !full;   // Overrun is dropped.
	assign pop = q_pop && q_valid;

	assign q_valid = (count != '0);
	assign q_tag = mem[rd_ptr];         // Head of queue.

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= req_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			req_credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two.
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			req_credit <= pop;           // One credit back per entry freed.
		end
	end

endmodule : lookup_request_queue

`default_nettype wire

//--- assoc_lookup_pkg.sv
`default_nettype none

package assoc_lookup_pkg;

	localparam int WAYS = 8;
	localparam int WAY_W = $clog2(WAYS);
	localparam int TAG_W = 12;
	localparam int LRU_W = WAYS - 1;            // One bit per inner tree node.
	localparam int NODE_W = $clog2(LRU_W);

	localparam int REQ_DEPTH = 4;
	localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
	localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);

	localparam int RSP_CREDITS = 2;
	localparam int RSP_CNT_W = $clog2(RSP_CREDITS + 1);

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [WAY_W-1:0] way_t;
	typedef logic [WAYS-1:0] way_mask_t;
	typedef logic [LRU_W-1:0] lru_bits_t;
	typedef logic [NODE_W-1:0] node_t;
	typedef logic [REQ_PTR_W-1:0] req_ptr_t;
	typedef logic [REQ_CNT_W-1:0] req_cnt_t;
	typedef logic [RSP_CNT_W-1:0] rsp_cnt_t;

	// Nodes from here up sit above the way pairs.
	localparam node_t LEAF_BASE = node_t'(LRU_W / 2);

	typedef enum logic [1:0] {
		idle,
		lookup,
		victim_wait,
		respond
	} seq_state_t;

	typedef enum logic {
		walk_idle,
		walking
	} plru_state_t;

endpackage : assoc_lookup_pkg

`default_nettype wire
